//--- files.f
fetch_pkg.sv
fetch_pc_mux.sv
fetch_prefetch.sv
fetch_aligner.sv
fetch_c_expander.sv
fetch_id_reg.sv
fetch_stage.sv
tb_instr_mem.sv
tb_fetch_stage.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the fetch stage testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_fetch_stage \
  -f files.f -o tb_fetch_stage > build.log 2>&1 \
  && ./obj_dir/tb_fetch_stage > sim.log 2>&1 \
  || echo "build or simulation returned an error"
cat sim.log 2>/dev/null
grep -q "^PASS: all tests$" sim.log 2>/dev/null && exit 0 || exit 1

//--- tb_fetch_stage.sv
// testbench for the fetch stage
// clock, reset, redirect stimulus, reference pc model and checking assertions

`timescale 1ns/10ps

module tb_fetch_stage import fetch_pkg::*; ();

  localparam logic [31:0] ErrAddr0  = 32'h0000_0a40;
  localparam logic [31:0] ErrAddr1  = 32'h0000_0c80;
  localparam logic [31:0] HaltAddr  = 32'h1A11_0800;
  localparam logic [31:0] DbgExAddr = 32'h1A11_0808;

  logic clk_i, rst_ni, req_i, pc_set_i, id_in_ready_i, instr_valid_clear_i;
  logic instr_req_o, instr_gnt_i, instr_rvalid_i, instr_err_i;
  logic [31:0] instr_addr_o, instr_rdata_i, boot_addr_i, branch_target_i;
  logic [31:0] csr_mepc_i, csr_depc_i, csr_mtvec_i, pc_if_o, pc_id_o, instr_rdata_id_o;
  logic instr_valid_id_o, instr_new_id_o, instr_is_compressed_id_o, instr_fetch_err_o;
  logic instr_fetch_err_plus2_o, illegal_c_insn_id_o, csr_mtvec_init_o, if_busy_o;
  logic [15:0] instr_rdata_c_id_o;
  logic [5:0]  exc_cause_i;
  pc_sel_e     pc_mux_i;
  exc_pc_sel_e exc_pc_mux_i;

  logic [31:0] exp_pc;      // reference pc of the next new instr
  logic [31:0] chk_instr;   // memory halfwords at pc_id_o
  logic        chk_err_lo;
  logic        chk_err_hi;
  logic [32:0] exp_bundle;  // illegal flag and expected instr
  logic        exp_c;
  int          i;

  fetch_stage #(
    .DmHaltAddr      (HaltAddr),
    .DmExceptionAddr (DbgExAddr),
    .FifoDepth       (2)
  ) dut0 (.*);

  tb_instr_mem #(.ErrAddr0(ErrAddr0), .ErrAddr1(ErrAddr1)) mem0 (
    .clk_i(clk_i), .rst_ni(rst_ni), .req_i(instr_req_o), .addr_i(instr_addr_o),
    .gnt_o(instr_gnt_i), .rvalid_o(instr_rvalid_i), .rdata_o(instr_rdata_i),
    .err_o(instr_err_i), .chk_addr_i(pc_id_o), .chk_instr_o(chk_instr),
    .chk_err_lo_o(chk_err_lo), .chk_err_hi_o(chk_err_hi)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  task automatic mismatch_stop(input string msg);
    $display("mismatch at %0t: %s", $time, msg);
    $display("FAIL: see errors above");
    $fatal(1);
  endtask

  task automatic timeout_stop(input string msg);
    $display("%s", msg);
    $display("FAIL: see errors above");
    $fatal(1);
  endtask

  // handler, boot and return addresses of the pc mux rule
  function automatic logic [31:0] target_ref();
    logic [31:0] t;
    case (pc_mux_i)
      PC_JUMP: t = branch_target_i;
      PC_ERET: t = csr_mepc_i;
      PC_DRET: t = csr_depc_i;
      PC_EXC: begin
        case (exc_pc_mux_i)
          EXC_PC_EXC: t = csr_mtvec_i & 32'hFFFF_FF00;
          EXC_PC_IRQ: t = (csr_mtvec_i & 32'hFFFF_FF00) + 32'd4 * 32'(exc_cause_i[4:0]);
          EXC_PC_DBD: t = HaltAddr;
          default:    t = DbgExAddr;
        endcase
      end
      default: t = (boot_addr_i & 32'hFFFF_FF00) + 32'h80;
    endcase
    return t & 32'hFFFF_FFFE;
  endfunction

  // compressed subset expansion with the illegal flag in the top bit
  function automatic logic [32:0] expand_ref(input logic [31:0] w);
    logic [15:0] c;
    logic [11:0] imm;
    logic [20:0] off;
    c   = w[15:0];
    imm = {{7{c[12]}}, c[6:2]};
    off = {{9{c[12]}}, c[12], c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3], 1'b0};
    if (c[1:0] == 2'b11) return {1'b0, w};
    case ({c[1:0], c[15:13]})
      5'b01_000: return {1'b0, imm, c[11:7], 3'b000, c[11:7], 7'h13};
      5'b01_010: return {1'b0, imm, 5'd0, 3'b000, c[11:7], 7'h13};
      5'b01_101: return {1'b0, off[20], off[10:1], off[11], off[19:12], 5'd0, 7'h6f};
      5'b10_100: begin
        if (c[6:2] != 5'd0) begin
          return {1'b0, 7'h00, c[6:2], (c[12] ? c[11:7] : 5'd0), 3'b000, c[11:7], 7'h33};
        end
      end
      default: ;
    endcase
    return {1'b1, 16'h0000, c};
  endfunction

  assign exp_bundle = expand_ref(chk_instr);
  assign exp_c      = (chk_instr[1:0] != 2'b11);

  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      exp_pc <= '0;
    end else if (pc_set_i) begin
      exp_pc <= target_ref();
    end else if (instr_new_id_o) begin
      exp_pc <= exp_pc + (exp_c ? 32'd2 : 32'd4);
    end
  end

  ////////////////////////////////////////
  // checks
  ////////////////////////////////////////

  pc_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_new_id_o |-> pc_id_o == exp_pc) else mismatch_stop("pc_id_o differs from reference pc");
  if_pc_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    pc_set_i |=> pc_if_o == exp_pc)
    else mismatch_stop("pc_if_o not at the redirect target");
  data_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_new_id_o |-> instr_rdata_id_o == exp_bundle[31:0])
    else mismatch_stop("instr_rdata_id_o differs from memory content");
  compressed_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_new_id_o |-> instr_is_compressed_id_o == exp_c)
    else mismatch_stop("instr_is_compressed_id_o wrong");
  illegal_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_new_id_o |-> illegal_c_insn_id_o == exp_bundle[32])
    else mismatch_stop("illegal_c_insn_id_o wrong");
  rdata_c_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_new_id_o |-> instr_rdata_c_id_o == chk_instr[15:0])
    else mismatch_stop("instr_rdata_c_id_o differs from low halfword");
  err_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_new_id_o |-> instr_fetch_err_o == (chk_err_lo | (~exp_c & chk_err_hi)))
    else mismatch_stop("instr_fetch_err_o wrong");
  plus2_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_new_id_o |-> instr_fetch_err_plus2_o == (~exp_c & chk_err_hi & ~chk_err_lo))
    else mismatch_stop("instr_fetch_err_plus2_o wrong");
  hold_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !id_in_ready_i && instr_valid_id_o |=> $stable(pc_id_o) && $stable(instr_rdata_id_o))
    else mismatch_stop("ID outputs changed under back-pressure");
  valid_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_valid_id_o && !instr_valid_clear_i |=> instr_valid_id_o)
    else mismatch_stop("instr_valid_id_o dropped without clear");
  busy_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_req_o && instr_gnt_i |=> if_busy_o)
    else mismatch_stop("if_busy_o low with a request outstanding");
  mtvec_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    csr_mtvec_init_o == (pc_set_i && pc_mux_i == PC_BOOT))
    else mismatch_stop("csr_mtvec_init_o not a pulse on boot pc set");

  ////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////

  task automatic next_cycle();
    @(posedge clk_i);
    #2;
    id_in_ready_i       = ($urandom % 4) != 0;
    instr_valid_clear_i = ($urandom % 3) == 0;
  endtask

  task automatic wait_new(input int n);
    int seen;
    int cycles;
    seen   = 0;
    cycles = 0;
    while (seen < n) begin
      next_cycle();
      cycles++;
      if (instr_new_id_o) seen++;
      if (cycles > 500) timeout_stop("timeout while waiting for a new instruction in ID");
    end
  endtask

  task automatic redirect(input int k);
    case (k % 7)
      0: begin
        pc_mux_i        = PC_JUMP;
        branch_target_i = ErrAddr0 - 32'd2;  // straddle error
      end
      1: begin
        pc_mux_i     = PC_EXC;
        exc_pc_mux_i = EXC_PC_EXC;
      end
      2: begin
        pc_mux_i     = PC_EXC;
        exc_pc_mux_i = EXC_PC_IRQ;
        exc_cause_i  = {1'b1, 5'($urandom % 32)};
      end
      3: begin
        pc_mux_i   = PC_ERET;
        csr_mepc_i = $urandom & 32'h0000_0FFE;
      end
      4: begin
        pc_mux_i   = PC_DRET;
        csr_depc_i = $urandom & 32'h0000_0FFE;
      end
      5: begin
        pc_mux_i     = PC_EXC;
        exc_pc_mux_i = k[0] ? EXC_PC_DBD : EXC_PC_DBG_EXC;
      end
      default: begin
        pc_mux_i        = (k == 20) ? PC_BOOT : PC_JUMP;
        branch_target_i = k[0] ? ErrAddr1 : ($urandom & 32'h0000_0FFE);
      end
    endcase
    csr_mtvec_i = $urandom & 32'h0000_0F00;
    pc_set_i    = 1'b1;
    next_cycle();
    pc_set_i    = 1'b0;
  endtask

  initial begin
    void'($urandom(86731));
    rst_ni              = 1'b0;
    req_i               = 1'b0;
    pc_set_i            = 1'b0;
    pc_mux_i            = PC_BOOT;
    exc_pc_mux_i        = EXC_PC_EXC;
    exc_cause_i         = '0;
    boot_addr_i         = 32'h0000_1000;
    branch_target_i     = '0;
    csr_mepc_i          = '0;
    csr_depc_i          = '0;
    csr_mtvec_i         = 32'h0000_0500;
    id_in_ready_i       = 1'b1;
    instr_valid_clear_i = 1'b0;
    repeat (4) @(posedge clk_i);
    #2 rst_ni = 1'b1;
    assert (!instr_req_o && !instr_valid_id_o && !instr_new_id_o && !if_busy_o &&
            !csr_mtvec_init_o)
      else mismatch_stop("outputs not low after reset");
    next_cycle();
    req_i    = 1'b1;  // boot
    pc_set_i = 1'b1;
    next_cycle();
    pc_set_i = 1'b0;
    wait_new(8);
    for (i = 0; i < 42; i++) begin
      redirect(i);
      wait_new(6);
    end
    $display("PASS: all tests");
    $finish;
  end

endmodule

//--- tb_instr_mem.sv
// instruction bus responder with random grant and rvalid delays
// fixed program content as a function of the address, error words
// combinational lookup port for the reference model

`timescale 1ns/10ps

module tb_instr_mem #(
  parameter logic [31:0] ErrAddr0 = 32'h0000_0a40,
  parameter logic [31:0] ErrAddr1 = 32'h0000_0c80
) (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        req_i,
  input  logic [31:0] addr_i,
  output logic        gnt_o,
  output logic        rvalid_o,
  output logic [31:0] rdata_o,
  output logic        err_o,
  input  logic [31:0] chk_addr_i,
  output logic [31:0] chk_instr_o,   // halfwords at chk_addr_i and chk_addr_i + 2
  output logic        chk_err_lo_o,
  output logic        chk_err_hi_o
);

  logic [31:0] pend_q[$];  // granted word addresses, in order
  logic [31:0] rsp_addr;
  int          gnt_wait;
  int          rsp_wait;

  function automatic logic is_err(input logic [31:0] a);
    return (a[31:2] == ErrAddr0[31:2]) || (a[31:2] == ErrAddr1[31:2]);
  endfunction

  function automatic logic [15:0] half_at(input logic [31:0] a);
    logic [31:0] h;
    logic [15:0] v;
    h = (a >> 1) * 32'h9E37_79B9;
    h = h ^ (h >> 15);
    v = h[31:16];
    case (h[2:0])
      3'd0, 3'd1: v[1:0] = 2'b11;                             // 32 bit start
      3'd2:       v = {3'b000, v[12:2], 2'b01};               // c.addi
      3'd3:       v = {3'b010, v[12:2], 2'b01};               // c.li
      3'd4:       v = {3'b101, v[12:2], 2'b01};               // c.j
      3'd5:       v = {3'b100, v[12:7], v[6:2] | 5'd1, 2'b10}; // c.mv or c.add
      default:    v = v;                                      // anything, often illegal
    endcase
    // straddling 32 bit instr right before each error word
    if ({a[31:1], 1'b0} == ErrAddr0 - 32'd2 || {a[31:1], 1'b0} == ErrAddr1 - 32'd2) begin
      v[1:0] = 2'b11;
    end
    return v;
  endfunction

  assign chk_instr_o  = {half_at(chk_addr_i + 32'd2), half_at(chk_addr_i)};
  assign chk_err_lo_o = is_err(chk_addr_i);
  assign chk_err_hi_o = is_err(chk_addr_i + 32'd2);

  initial begin
    gnt_o    = 1'b0;
    rvalid_o = 1'b0;
    rdata_o  = '0;
    err_o    = 1'b0;
    gnt_wait = 0;
    rsp_wait = 0;
    forever begin
      @(posedge clk_i);
      if (!rst_ni) begin
        pend_q.delete();
      end else begin
        if (req_i && gnt_o) begin
          pend_q.push_back(addr_i);
          gnt_wait = $urandom % 4;
        end else if (gnt_wait > 0) begin
          gnt_wait--;
        end
        if (rvalid_o) begin
          rsp_wait = $urandom % 4;
        end else if (rsp_wait > 0) begin
          rsp_wait--;
        end
      end
      #2;
      gnt_o    = rst_ni && (gnt_wait == 0);
      rvalid_o = 1'b0;
      err_o    = 1'b0;
      if (rst_ni && pend_q.size() > 0 && rsp_wait == 0) begin
        rsp_addr = pend_q.pop_front();
        rvalid_o = 1'b1;
        rdata_o  = {half_at(rsp_addr + 32'd2), half_at(rsp_addr)};
        err_o    = is_err(rsp_addr);
      end
    end
  end

endmodule

//--- fetch_stage.sv
// instruction fetch stage top level
// pc mux, prefetch, aligner, compressed expander and IF-ID register

`timescale 1ns/10ps

module fetch_stage import fetch_pkg::*; #(
  parameter logic [XLEN-1:0] DmHaltAddr      = 32'h1A11_0800,
  parameter logic [XLEN-1:0] DmExceptionAddr = 32'h1A11_0808,
  parameter int unsigned     FifoDepth       = 2
) (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic [XLEN-1:0] boot_addr_i,
  input  logic            req_i,
  // instruction bus
  output logic            instr_req_o,
  output logic [XLEN-1:0] instr_addr_o,
  input  logic            instr_gnt_i,
  input  logic            instr_rvalid_i,
  input  logic [XLEN-1:0] instr_rdata_i,
  input  logic            instr_err_i,
  // towards ID
  output logic            instr_valid_id_o,
  output logic            instr_new_id_o,
  output logic [XLEN-1:0] instr_rdata_id_o,
  output logic [15:0]     instr_rdata_c_id_o,
  output logic            instr_is_compressed_id_o,
  output logic            instr_fetch_err_o,
  output logic            instr_fetch_err_plus2_o,
  output logic            illegal_c_insn_id_o,
  output logic [XLEN-1:0] pc_if_o,
  output logic [XLEN-1:0] pc_id_o,
  // control
  input  logic            instr_valid_clear_i,
  input  logic            pc_set_i,
  input  pc_sel_e         pc_mux_i,
  input  exc_pc_sel_e     exc_pc_mux_i,
  input  logic [5:0]      exc_cause_i,      // msb flags an interrupt
  input  logic [XLEN-1:0] branch_target_i,
  input  logic [XLEN-1:0] csr_mepc_i,
  input  logic [XLEN-1:0] csr_depc_i,
  input  logic [XLEN-1:0] csr_mtvec_i,
  output logic            csr_mtvec_init_o,
  input  logic            id_in_ready_i,
  output logic            if_busy_o
);

  logic [XLEN-1:0] fetch_addr_n;
  logic            word_valid;
  logic            word_ready;
  logic [XLEN-1:0] word_rdata;
  logic [XLEN-1:0] word_addr;
  logic            word_err;
  logic            fetch_valid;
  logic            fetch_err;
  logic            fetch_err_plus2;
  instr_word_u     instr_raw;
  logic [XLEN-1:0] instr_exp;
  logic            is_compressed;
  logic            illegal_c;

  fetch_pc_mux #(
    .DmHaltAddr      (DmHaltAddr),
    .DmExceptionAddr (DmExceptionAddr)
  ) u_pc_mux (
    .boot_addr_i      (boot_addr_i),
    .pc_mux_i         (pc_mux_i),
    .exc_pc_mux_i     (exc_pc_mux_i),
    .exc_irq_id_i     (exc_cause_i[IrqIdW-1:0]),
    .branch_target_i  (branch_target_i),
    .csr_mepc_i       (csr_mepc_i),
    .csr_depc_i       (csr_depc_i),
    .csr_mtvec_i      (csr_mtvec_i),
    .pc_set_i         (pc_set_i),
    .fetch_addr_n_o   (fetch_addr_n),
    .csr_mtvec_init_o (csr_mtvec_init_o)
  );

  fetch_prefetch #(
    .FifoDepth (FifoDepth)
  ) u_prefetch (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .req_i          (req_i),
    .branch_i       (pc_set_i),
    .branch_addr_i  (fetch_addr_n),
    .word_ready_i   (word_ready),
    .instr_gnt_i    (instr_gnt_i),
    .instr_rvalid_i (instr_rvalid_i),
    .instr_rdata_i  (instr_rdata_i),
    .instr_err_i    (instr_err_i),
    .word_valid_o   (word_valid),
    .word_rdata_o   (word_rdata),
    .word_addr_o    (word_addr),
    .word_err_o     (word_err),
    .instr_req_o    (instr_req_o),
    .instr_addr_o   (instr_addr_o),
    .busy_o         (if_busy_o)
  );

  fetch_aligner u_aligner (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .branch_i          (pc_set_i),
    .branch_addr_i     (fetch_addr_n),
    .word_valid_i      (word_valid),
    .word_rdata_i      (word_rdata),
    .word_addr_i       (word_addr),
    .word_err_i        (word_err),
    .word_ready_o      (word_ready),
    .fetch_ready_i     (id_in_ready_i),
    .fetch_valid_o     (fetch_valid),
    .fetch_pc_o        (pc_if_o),
    .instr_raw_o       (instr_raw),
    .fetch_err_o       (fetch_err),
    .fetch_err_plus2_o (fetch_err_plus2)
  );

  fetch_c_expander u_c_expander (
    .instr_i         (instr_raw),
    .instr_o         (instr_exp),
    .is_compressed_o (is_compressed),
    .illegal_c_o     (illegal_c)
  );

  fetch_id_reg u_id_reg (
    .clk_i                    (clk_i),
    .rst_ni                   (rst_ni),
    .fetch_valid_i            (fetch_valid),
    .id_in_ready_i            (id_in_ready_i),
    .pc_set_i                 (pc_set_i),
    .instr_valid_clear_i      (instr_valid_clear_i),
    .instr_i                  (instr_exp),
    .instr_raw_i              (instr_raw),
    .is_compressed_i          (is_compressed),
    .illegal_c_i              (illegal_c),
    .fetch_err_i              (fetch_err),
    .fetch_err_plus2_i        (fetch_err_plus2),
    .fetch_pc_i               (pc_if_o),
    .instr_valid_id_o         (instr_valid_id_o),
    .instr_new_id_o           (instr_new_id_o),
    .instr_rdata_id_o         (instr_rdata_id_o),
    .instr_rdata_c_id_o       (instr_rdata_c_id_o),
    .instr_is_compressed_id_o (instr_is_compressed_id_o),
    .illegal_c_insn_id_o      (illegal_c_insn_id_o),
    .instr_fetch_err_o        (instr_fetch_err_o),
    .instr_fetch_err_plus2_o  (instr_fetch_err_plus2_o),
    .pc_id_o                  (pc_id_o)
  );

endmodule

//--- fetch_id_reg.sv
// IF-ID pipeline register
// valid and new flags, instruction and error payload

`timescale 1ns/10ps

module fetch_id_reg import fetch_pkg::*; (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            fetch_valid_i,
  input  logic            id_in_ready_i,
  input  logic            pc_set_i,
  input  logic            instr_valid_clear_i,
  input  logic [XLEN-1:0] instr_i,
  input  instr_word_u     instr_raw_i,
  input  logic            is_compressed_i,
  input  logic            illegal_c_i,
  input  logic            fetch_err_i,
  input  logic            fetch_err_plus2_i,
  input  logic [XLEN-1:0] fetch_pc_i,
  output logic            instr_valid_id_o,
  output logic            instr_new_id_o,
  output logic [XLEN-1:0] instr_rdata_id_o,
  output logic [15:0]     instr_rdata_c_id_o,
  output logic            instr_is_compressed_id_o,
  output logic            illegal_c_insn_id_o,
  output logic            instr_fetch_err_o,
  output logic            instr_fetch_err_plus2_o,
  output logic [XLEN-1:0] pc_id_o
);

  logic we;  // capture beat

  assign we = fetch_valid_i & id_in_ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      instr_valid_id_o <= 1'b0;
      instr_new_id_o   <= 1'b0;
    end else begin
      // a redirect in the capture cycle squashes the new instr
      instr_valid_id_o <= (we & ~pc_set_i) | (instr_valid_id_o & ~instr_valid_clear_i);
      instr_new_id_o   <= we;
    end
  end

  always_ff @(posedge clk_i) begin
    if (we) begin
      instr_rdata_id_o         <= instr_i;
      instr_rdata_c_id_o       <= {instr_raw_i.rvc.funct3, instr_raw_i.rvc.b12,
                                   instr_raw_i.rvc.rd_rs1, instr_raw_i.rvc.rs2,
                                   instr_raw_i.rvc.op};
      instr_is_compressed_id_o <= is_compressed_i;
      illegal_c_insn_id_o      <= illegal_c_i;
      instr_fetch_err_o        <= fetch_err_i;
      instr_fetch_err_plus2_o  <= fetch_err_plus2_i;
      pc_id_o                  <= fetch_pc_i;
    end
  end

endmodule

//--- fetch_c_expander.sv
// expansion of c.addi, c.li, c.j, c.mv and c.add
// illegal flag for the other compressed encodings

`timescale 1ns/10ps

module fetch_c_expander import fetch_pkg::*; (
  input  instr_word_u     instr_i,
  output logic [XLEN-1:0] instr_o,
  output logic            is_compressed_o,
  output logic            illegal_c_o
);

  instr_word_u exp;
  logic [11:0] imm;   // c.addi and c.li immediate
  logic [15:0] c;

  assign c               = instr_i[15:0];
  assign imm             = {{6{instr_i.rvc.b12}}, instr_i.rvc.b12, instr_i.rvc.rs2};
  assign is_compressed_o = (instr_i.rvc.op != 2'b11);
  assign instr_o         = exp;

  always_comb begin
    exp         = instr_i;  // 32 bit instrs and illegal ones pass as they are
    illegal_c_o = 1'b0;
    if (is_compressed_o) begin
      unique case ({instr_i.rvc.op, instr_i.rvc.funct3})
        5'b01_000, 5'b01_010: begin
          // addi rd, rd, imm or addi rd, x0, imm
          exp.rv32.funct7 = imm[11:5];
          exp.rv32.rs2    = imm[4:0];
          exp.rv32.rs1    = instr_i.rvc.funct3[1] ? 5'd0 : instr_i.rvc.rd_rs1;
          exp.rv32.funct3 = 3'b000;
          exp.rv32.rd     = instr_i.rvc.rd_rs1;
          exp.rv32.opcode = 7'h13;
        end
        5'b01_101: begin  // c.j to jal x0
          exp = {c[12], c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3],
                 {9{c[12]}}, 5'd0, 7'h6f};
        end
        5'b10_100: begin
          if (instr_i.rvc.rs2 == 5'd0) begin
            illegal_c_o = 1'b1;  // c.jr, c.jalr, c.ebreak
          end else begin
            // add rd, x0, rs2 or add rd, rd, rs2
            exp.rv32.funct7 = 7'h00;
            exp.rv32.rs2    = instr_i.rvc.rs2;
            exp.rv32.rs1    = instr_i.rvc.b12 ? instr_i.rvc.rd_rs1 : 5'd0;
            exp.rv32.funct3 = 3'b000;
            exp.rv32.rd     = instr_i.rvc.rd_rs1;
            exp.rv32.opcode = 7'h33;
          end
        end
        default: illegal_c_o = 1'b1;
      endcase
    end
  end

endmodule

//--- fetch_aligner.sv
// halfword realignment of 16 and 32 bit instructions
// stored upper half for straddling instructions, plus2 error

`timescale 1ns/10ps

module fetch_aligner import fetch_pkg::*; (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            branch_i,
  input  logic [XLEN-1:0] branch_addr_i,
  input  logic            word_valid_i,
  input  logic [XLEN-1:0] word_rdata_i,
  input  logic [XLEN-1:0] word_addr_i,
  input  logic            word_err_i,
  output logic            word_ready_o,
  input  logic            fetch_ready_i,
  output logic            fetch_valid_o,
  output logic [XLEN-1:0] fetch_pc_o,
  output instr_word_u     instr_raw_o,
  output logic            fetch_err_o,
  output logic            fetch_err_plus2_o
);

  logic [XLEN-1:0] pc_q;
  logic            hold_valid_q;  // upper half of the previous word is kept
  logic [15:0]     hold_data_q;
  logic            hold_err_q;
  logic [15:0]     lo_half;
  logic [15:0]     hi_half;
  instr_word_u     cand;
  logic            is_c;
  logic            straddle;
  logic            adv;
  logic            fire;

  assign lo_half = hold_valid_q ? hold_data_q :
                   (pc_q[1] ? word_rdata_i[XLEN-1:16] : word_rdata_i[15:0]);
  assign hi_half = hold_valid_q ? word_rdata_i[15:0] : word_rdata_i[XLEN-1:16];

  always_comb begin
    cand        = {hi_half, lo_half};
    is_c        = (cand.rvc.op != 2'b11);
    instr_raw_o = cand;
    if (is_c) begin
      instr_raw_o.rvc.hi = '0;
    end
  end

  // 32 bit instr starting in the upper half, needs the next word
  assign straddle = ~hold_valid_q & pc_q[1] & ~is_c;
  assign adv      = word_valid_i & fetch_ready_i & ~branch_i;

  assign fetch_valid_o     = word_valid_i & ~branch_i & ~straddle;
  assign fire              = fetch_valid_o & fetch_ready_i;
  assign fetch_pc_o        = pc_q;
  assign fetch_err_o       = word_err_i | (hold_valid_q & hold_err_q);
  assign fetch_err_plus2_o = hold_valid_q & word_err_i & ~hold_err_q;
  // a compressed low half leaves the word for its upper half
  assign word_ready_o      = adv & ~hold_valid_q & (pc_q[1] | ~is_c);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pc_q         <= '0;
      hold_valid_q <= 1'b0;
    end else if (branch_i) begin
      pc_q         <= {branch_addr_i[XLEN-1:1], 1'b0};
      hold_valid_q <= 1'b0;
    end else if (fire) begin
      pc_q         <= pc_q + (is_c ? XLEN'(2) : XLEN'(4));
      hold_valid_q <= 1'b0;
    end else if (adv & straddle) begin
      hold_valid_q <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (adv & straddle) begin
      hold_data_q <= word_rdata_i[XLEN-1:16];
      hold_err_q  <= word_err_i;
    end
  end

  // prefetch must hand over the word that holds the next halfword
  word_order_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    word_valid_i & ~branch_i |->
      word_addr_i[XLEN-1:2] == pc_q[XLEN-1:2] + (XLEN-2)'(hold_valid_q));

endmodule

//--- fetch_prefetch.sv
// bus request engine with up to two outstanding requests
// response discard after a branch and word FIFO towards the aligner

`timescale 1ns/10ps

module fetch_prefetch import fetch_pkg::*; #(
  parameter int unsigned FifoDepth = 2
) (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            req_i,
  input  logic            branch_i,
  input  logic [XLEN-1:0] branch_addr_i,
  input  logic            word_ready_i,
  input  logic            instr_gnt_i,
  input  logic            instr_rvalid_i,
  input  logic [XLEN-1:0] instr_rdata_i,
  input  logic            instr_err_i,
  output logic            word_valid_o,
  output logic [XLEN-1:0] word_rdata_o,
  output logic [XLEN-1:0] word_addr_o,
  output logic            word_err_o,
  output logic            instr_req_o,
  output logic [XLEN-1:0] instr_addr_o,
  output logic            busy_o
);

  localparam int unsigned     CntW   = $clog2(FifoDepth + 1);
  localparam int unsigned     PtrW   = $clog2(FifoDepth);
  localparam logic [CntW-1:0] MaxOut = CntW'(2);

  logic            hold_q;        // request waiting for its grant
  logic            hold_stale_q;  // held request predates a branch
  logic [XLEN-1:0] hold_addr_q;
  logic [XLEN-1:0] next_addr_q;   // next sequential word
  logic [XLEN-1:0] rsp_addr_q;    // address of the next kept response
  logic [XLEN-1:0] branch_word;
  logic [CntW-1:0] out_cnt_q;
  logic [CntW-1:0] disc_cnt_q;
  logic [CntW-1:0] fifo_cnt_q;
  logic [CntW-1:0] live_cnt;
  logic [CntW-1:0] free_cnt;
  logic            new_req;
  logic            gnt;
  logic            push;
  logic            pop;
  logic [PtrW-1:0] wr_ptr_q;
  logic [PtrW-1:0] rd_ptr_q;
  logic [XLEN-1:0] rdata_mem [FifoDepth];
  logic [XLEN-1:0] addr_mem  [FifoDepth];
  logic            err_mem   [FifoDepth];

  function automatic logic [PtrW-1:0] ptr_inc(input logic [PtrW-1:0] p);
    return (p == PtrW'(FifoDepth - 1)) ? '0 : p + 1'b1;
  endfunction

  ////////////////////////////////////////
  // requests
  ////////////////////////////////////////

  assign branch_word = {branch_addr_i[XLEN-1:2], 2'b00};
  assign live_cnt    = out_cnt_q - disc_cnt_q;
  assign free_cnt    = CntW'(FifoDepth) - fifo_cnt_q;
  // keep room in the FIFO for every live response
  assign new_req     = req_i & ~hold_q & (out_cnt_q < MaxOut) &
                       (branch_i | (free_cnt > live_cnt));

  assign instr_req_o  = hold_q | new_req;
  assign instr_addr_o = hold_q ? hold_addr_q : (branch_i ? branch_word : next_addr_q);
  assign gnt          = instr_req_o & instr_gnt_i;
  assign push         = instr_rvalid_i & (disc_cnt_q == '0) & ~branch_i;
  assign busy_o       = hold_q | (out_cnt_q != '0);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      hold_q       <= 1'b0;
      hold_stale_q <= 1'b0;
      next_addr_q  <= '0;
      rsp_addr_q   <= '0;
      out_cnt_q    <= '0;
      disc_cnt_q   <= '0;
    end else begin
      hold_q       <= instr_req_o & ~instr_gnt_i;
      hold_stale_q <= hold_q & ~instr_gnt_i & (hold_stale_q | branch_i);
      out_cnt_q    <= out_cnt_q + CntW'(gnt) - CntW'(instr_rvalid_i);
      if (branch_i) begin
        next_addr_q <= new_req ? branch_word + XLEN'(4) : branch_word;
        rsp_addr_q  <= branch_word;
        // everything still owed belongs to the old stream
        disc_cnt_q  <= out_cnt_q - CntW'(instr_rvalid_i) + CntW'(gnt & hold_q);
      end else begin
        if (new_req) begin
          next_addr_q <= next_addr_q + XLEN'(4);
        end
        if (push) begin
          rsp_addr_q <= rsp_addr_q + XLEN'(4);
        end
        disc_cnt_q <= disc_cnt_q - CntW'(instr_rvalid_i & ~push) +
                      CntW'(gnt & hold_q & hold_stale_q);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (new_req) begin
      hold_addr_q <= instr_addr_o;
    end
  end

  ////////////////////////////////////////
  // word FIFO
  ////////////////////////////////////////

  assign word_valid_o = (fifo_cnt_q != '0);
  assign word_rdata_o = rdata_mem[rd_ptr_q];
  assign word_addr_o  = addr_mem[rd_ptr_q];
  assign word_err_o   = err_mem[rd_ptr_q];
  assign pop          = word_valid_o & word_ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      fifo_cnt_q <= '0;
    end else if (branch_i) begin  // flush
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      fifo_cnt_q <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      fifo_cnt_q <= fifo_cnt_q + CntW'(push) - CntW'(pop);
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      rdata_mem[wr_ptr_q] <= instr_rdata_i;
      addr_mem[wr_ptr_q]  <= rsp_addr_q;
      err_mem[wr_ptr_q]   <= instr_err_i;
    end
  end

  err_with_rvalid_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_err_i |-> instr_rvalid_i);
  addr_aligned_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_req_o |-> (instr_addr_o[1:0] == 2'b00));
  addr_known_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_req_o |-> !$isunknown(instr_addr_o));

endmodule

//--- fetch_pc_mux.sv
// handler address and next fetch address selection
// mtvec init pulse on boot

`timescale 1ns/10ps

module fetch_pc_mux import fetch_pkg::*; #(
  parameter logic [XLEN-1:0] DmHaltAddr      = 32'h1A11_0800,
  parameter logic [XLEN-1:0] DmExceptionAddr = 32'h1A11_0808
) (
  input  logic [XLEN-1:0]   boot_addr_i,
  input  pc_sel_e           pc_mux_i,
  input  exc_pc_sel_e       exc_pc_mux_i,
  input  logic [IrqIdW-1:0] exc_irq_id_i,
  input  logic [XLEN-1:0]   branch_target_i,
  input  logic [XLEN-1:0]   csr_mepc_i,
  input  logic [XLEN-1:0]   csr_depc_i,
  input  logic [XLEN-1:0]   csr_mtvec_i,
  input  logic              pc_set_i,
  output logic [XLEN-1:0]   fetch_addr_n_o,
  output logic              csr_mtvec_init_o
);

  logic [XLEN-1:0] exc_pc;
  logic [XLEN-1:0] next_pc;

  always_comb begin
    unique case (exc_pc_mux_i)
      EXC_PC_EXC:     exc_pc = {csr_mtvec_i[XLEN-1:8], 8'h00};
      EXC_PC_IRQ:     exc_pc = {csr_mtvec_i[XLEN-1:8], 1'b0, exc_irq_id_i, 2'b00};  // vectored
      EXC_PC_DBD:     exc_pc = DmHaltAddr;
      EXC_PC_DBG_EXC: exc_pc = DmExceptionAddr;
    endcase
  end

  always_comb begin
    unique case (pc_mux_i)
      PC_JUMP: next_pc = branch_target_i;
      PC_EXC:  next_pc = exc_pc;
      PC_ERET: next_pc = csr_mepc_i;
      PC_DRET: next_pc = csr_depc_i;
      default: next_pc = {boot_addr_i[XLEN-1:8], BootOffset};
    endcase
  end

  assign fetch_addr_n_o   = {next_pc[XLEN-1:1], 1'b0};  // halfword boundary
  assign csr_mtvec_init_o = pc_set_i & (pc_mux_i == PC_BOOT);

  // boot base must leave the offset byte free
  always_comb begin
    if (csr_mtvec_init_o) begin
      assert (boot_addr_i[7:0] == 8'h00)
        else $error("boot address not aligned to 256 bytes");
    end
  end

endmodule

//--- fetch_pkg.sv
// shared widths and boot offset for the fetch stage
// pc and handler selector enums
// instruction word union with rv32 and compressed views

package fetch_pkg;

  parameter int unsigned XLEN       = 32;
  parameter int unsigned IrqIdW     = 5;      // irq id bits of the exception cause
  parameter logic [7:0]  BootOffset = 8'h80;  // added to the 256 byte boot base

  // next pc source
  typedef enum logic [2:0] {
    PC_BOOT,
    PC_JUMP,
    PC_EXC,
    PC_ERET,
    PC_DRET
  } pc_sel_e;

  // handler address source
  typedef enum logic [1:0] {
    EXC_PC_EXC,
    EXC_PC_IRQ,
    EXC_PC_DBD,
    EXC_PC_DBG_EXC
  } exc_pc_sel_e;

  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } rv32;
    struct packed {
      logic [15:0] hi;      // not part of a compressed instr
      logic [2:0]  funct3;
      logic        b12;
      logic [4:0]  rd_rs1;
      logic [4:0]  rs2;
      logic [1:0]  op;      // 2'b11 marks a 32 bit instr
    } rvc;
  } instr_word_u;

endpackage
